// ==== all.f ====
common/icache_pkg.sv
common/icache_refill_if.sv
icache/icache_way_mem.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
src/icache_top.sv
verification/tb_mem_model.sv
verification/tb_icache.sv

// ==== common/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int INDEX_WIDTH  = 6;                    // 64 sets
    localparam int OFFSET_WIDTH = 6;                    // 64-byte lines
    localparam int TAG_WIDTH    = 20;                   // addr[31:12]
    localparam int SET_NUM      = 1 << INDEX_WIDTH;
    localparam int LINE_BITS    = 512;
    localparam int PACKET_BITS  = 64;                   // one doubleword per fetch

    // memory burst length codes, memory sees len + 1 words
    localparam logic [7:0] REFILL_LEN  = 8'd15;
    localparam logic [7:0] UNCACHE_LEN = 8'd1;

    // fetch address error
    localparam logic [6:0] FAULT_ADEF = 7'h08;

    typedef enum logic [2:0] {
        cs_idle,
        cs_lookup,
        cs_miss,
        cs_refill,
        cs_cacop
    } cache_state_e;

    typedef enum logic [1:0] {
        index_invalidate = 2'b01,   // way picked by addr[0]
        hit_invalidate   = 2'b10
    } cacop_code_e;

endpackage

// ==== common/icache_refill_if.sv ====
interface icache_refill_if;
    import icache_pkg::*;

    logic                 start;        // pulse when the controller leaves lookup for memory
    logic [31:0]          addr;
    logic                 uncached;
    logic                 done;         // memory handshake seen
    logic [LINE_BITS-1:0] line;         // return buffer

    modport ctrl (
        output start,
        output addr,
        output uncached,
        input  done,
        input  line
    );

    modport refill (
        input  start,
        input  addr,
        input  uncached,
        output done,
        output line
    );

endinterface

// ==== icache/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_req_valid,
    input  logic [31:0]                        i_req_addr,
    input  logic                               i_uncache,
    output logic                               o_req_ready,
    output logic                               o_resp_valid,
    output logic [31:0]                        o_resp_addr,
    output logic [icache_pkg::PACKET_BITS-1:0] o_resp_data,
    output logic [6:0]                         o_fault,
    input  logic                               i_cacop_valid,
    input  logic [1:0]                         i_cacop_code,
    output logic                               o_cacop_done,
    icache_refill_if.ctrl                      refill,
    output logic [icache_pkg::INDEX_WIDTH-1:0] o_rindex,
    input  logic [icache_pkg::TAG_WIDTH:0]     i_way0_tagv,
    input  logic [icache_pkg::TAG_WIDTH:0]     i_way1_tagv,
    input  logic [icache_pkg::LINE_BITS-1:0]   i_way0_line,
    input  logic [icache_pkg::LINE_BITS-1:0]   i_way1_line,
    output logic [1:0]                         o_way_we,
    output logic [icache_pkg::INDEX_WIDTH-1:0] o_windex,
    output logic [icache_pkg::TAG_WIDTH:0]     o_wtagv,
    output logic [icache_pkg::LINE_BITS-1:0]   o_wline
);
    import icache_pkg::*;

    cache_state_e           state;
    cache_state_e           next_state;
    logic [31:0]            req_buf;
    logic                   uncache_buf;
    cacop_code_e            code_buf;
    logic [SET_NUM-1:0]     lru;            // way to replace next, per set
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [INDEX_WIDTH-1:0] req_index;
    logic [1:0]             hit;
    logic                   cache_hit;
    logic                   misaligned;
    logic                   hit_ok;
    logic                   victim;
    logic                   accept_req;
    logic                   accept_cacop;
    logic [LINE_BITS-1:0]   sel_line;
    logic [PACKET_BITS-1:0] packet;

    assign req_tag   = req_buf[31:INDEX_WIDTH+OFFSET_WIDTH];
    assign req_index = req_buf[INDEX_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
    assign o_rindex  = i_req_addr[INDEX_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];

    // arrays were read with the buffered address last cycle
    assign hit[0]     = i_way0_tagv[TAG_WIDTH] && (i_way0_tagv[TAG_WIDTH-1:0] == req_tag);
    assign hit[1]     = i_way1_tagv[TAG_WIDTH] && (i_way1_tagv[TAG_WIDTH-1:0] == req_tag);
    assign cache_hit  = |hit;
    assign misaligned = |req_buf[1:0];
    assign hit_ok     = cache_hit && !uncache_buf && !misaligned;
    assign victim     = lru[req_index];

    // cache op has priority over a fetch in idle
    assign o_req_ready  = ((state == cs_idle) && !i_cacop_valid)
                        || ((state == cs_lookup) && hit_ok)
                        || (state == cs_refill);
    assign accept_req   = o_req_ready && i_req_valid;
    assign accept_cacop = (state == cs_idle) && i_cacop_valid;

    always_ff @(posedge clk) begin
        if (accept_req || accept_cacop) begin
            req_buf     <= i_req_addr;
            uncache_buf <= i_uncache;
        end
        if (accept_cacop) begin
            code_buf <= cacop_code_e'(i_cacop_code);
        end
    end

    // refill request
    assign refill.start    = (state == cs_lookup) && !misaligned && (uncache_buf || !cache_hit);
    assign refill.addr     = req_buf;
    assign refill.uncached = uncache_buf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= cs_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cs_idle: begin
                if (accept_cacop) begin
                    next_state = cs_cacop;
                end else if (accept_req) begin
                    next_state = cs_lookup;
                end
            end
            cs_lookup: begin
                if (misaligned) begin
                    next_state = cs_idle;
                end else if (refill.start) begin
                    next_state = refill.done ? cs_refill : cs_miss;  // ready may come at once
                end else begin
                    next_state = accept_req ? cs_lookup : cs_idle;
                end
            end
            cs_miss: begin
                if (refill.done) begin
                    next_state = cs_refill;
                end
            end
            cs_refill: next_state = accept_req ? cs_lookup : cs_idle;
            cs_cacop:  next_state = cs_idle;
            default:   next_state = cs_idle;
        endcase
    end

    // hit way or freshly returned line
    assign sel_line = (state == cs_refill) ? refill.line
                    : (hit[0] ? i_way0_line : i_way1_line);
    assign packet   = sel_line[req_buf[5:3] * PACKET_BITS +: PACKET_BITS];

    assign o_resp_addr = req_buf;

    always_comb begin
        o_resp_valid = 1'b0;
        o_resp_data  = '0;
        o_fault      = '0;
        case (state)
            cs_lookup: begin
                if (misaligned) begin
                    o_resp_valid = 1'b1;
                    o_fault      = FAULT_ADEF;
                end else if (hit_ok) begin
                    o_resp_valid = 1'b1;
                    o_resp_data  = packet;
                end
            end
            cs_refill: begin
                o_resp_valid = 1'b1;
                o_resp_data  = uncache_buf ? refill.line[PACKET_BITS-1:0] : packet;
            end
            default: ;
        endcase
    end

    assign o_windex = req_index;
    assign o_wline  = refill.line;

    // fill the victim way, or clear a valid bit for a cache op
    always_comb begin
        o_way_we = 2'b00;
        o_wtagv  = '0;
        if ((state == cs_refill) && !uncache_buf) begin
            o_way_we[victim] = 1'b1;
            o_wtagv          = {1'b1, req_tag};
        end else if (state == cs_cacop) begin
            case (code_buf)
                index_invalidate: o_way_we[req_buf[0]] = 1'b1;
                hit_invalidate:   o_way_we = hit;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if ((state == cs_lookup) && hit_ok) begin
            lru[req_index] <= hit[0];       // point at the other way
        end else if ((state == cs_refill) && !uncache_buf) begin
            lru[req_index] <= ~victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_cacop_done <= 1'b0;
        end else begin
            o_cacop_done <= (state == cs_cacop);
        end
    end

endmodule

// ==== icache/icache_refill.sv ====
module icache_refill (
    input  logic                             clk,
    input  logic                             rstn,
    icache_refill_if.refill                  refill,
    output logic                             o_mem_req,
    output logic [31:0]                      o_mem_addr,
    output logic [7:0]                       o_mem_len,
    input  logic                             i_mem_ready,
    input  logic [icache_pkg::LINE_BITS-1:0] i_mem_data
);
    import icache_pkg::*;

    logic                 req_hold;     // request waiting for ready
    logic                 handshake;
    logic [LINE_BITS-1:0] ret_buf;

    // request goes out in the cycle the miss is found
    assign o_mem_req = refill.start | req_hold;
    assign handshake = o_mem_req & i_mem_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_hold <= 1'b0;
        end else if (handshake) begin
            req_hold <= 1'b0;
        end else if (refill.start) begin
            req_hold <= 1'b1;
        end
    end

    // doubleword for uncached, whole line otherwise
    assign o_mem_addr = refill.uncached ? {refill.addr[31:3], 3'b000}
                                        : {refill.addr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign o_mem_len  = refill.uncached ? UNCACHE_LEN : REFILL_LEN;

    always_ff @(posedge clk) begin
        if (handshake) begin
            ret_buf <= i_mem_data;
        end
    end

    assign refill.done = handshake;
    assign refill.line = ret_buf;

endmodule

// ==== icache/icache_way_mem.sv ====
module icache_way_mem (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] i_rindex,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] i_windex,
    input  logic                               i_we,
    input  logic [icache_pkg::TAG_WIDTH:0]     i_wtagv,     // {valid, tag}
    input  logic [icache_pkg::LINE_BITS-1:0]   i_wline,
    output logic [icache_pkg::TAG_WIDTH:0]     o_tagv,
    output logic [icache_pkg::LINE_BITS-1:0]   o_line
);
    import icache_pkg::*;

    logic [SET_NUM-1:0]   valid_q;
    logic [TAG_WIDTH-1:0] tag_mem  [SET_NUM];
    logic [LINE_BITS-1:0] line_mem [SET_NUM];
    logic                 line_we;
    logic                 same_set;

    // clearing a tag leaves the data alone
    assign line_we  = i_we & i_wtagv[TAG_WIDTH];
    assign same_set = i_we && (i_windex == i_rindex);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_windex] <= i_wtagv[TAG_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_windex] <= i_wtagv[TAG_WIDTH-1:0];
        end
        if (line_we) begin
            line_mem[i_windex] <= i_wline;
        end
    end

    // registered read, new data forwarded when the same set is written
    always_ff @(posedge clk) begin
        o_tagv <= same_set ? i_wtagv : {valid_q[i_rindex], tag_mem[i_rindex]};
        o_line <= (same_set && line_we) ? i_wline : line_mem[i_rindex];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_icache -f all.f -o sim_icache

out=$(./obj_dir/sim_icache)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi

// ==== src/icache_top.sv ====
module icache_top (
    input  logic                               clk,
    input  logic                               rstn,
    // fetch side
    input  logic                               i_req_valid,
    input  logic [31:0]                        i_req_addr,
    input  logic                               i_uncache,
    output logic                               o_req_ready,
    output logic                               o_resp_valid,
    output logic [31:0]                        o_resp_addr,
    output logic [icache_pkg::PACKET_BITS-1:0] o_resp_data,
    output logic [6:0]                         o_fault,
    // cache operations
    input  logic                               i_cacop_valid,
    input  logic [1:0]                         i_cacop_code,
    output logic                               o_cacop_done,
    // memory side
    output logic                               o_mem_req,
    output logic [31:0]                        o_mem_addr,
    output logic [7:0]                         o_mem_len,
    input  logic                               i_mem_ready,
    input  logic [icache_pkg::LINE_BITS-1:0]   i_mem_data
);
    import icache_pkg::*;

    logic [INDEX_WIDTH-1:0] rindex;
    logic [INDEX_WIDTH-1:0] windex;
    logic [TAG_WIDTH:0]     way0_tagv;
    logic [TAG_WIDTH:0]     way1_tagv;
    logic [TAG_WIDTH:0]     wtagv;
    logic [LINE_BITS-1:0]   way0_line;
    logic [LINE_BITS-1:0]   way1_line;
    logic [LINE_BITS-1:0]   wline;
    logic [1:0]             way_we;

    icache_refill_if refill_bus ();

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_req_valid   (i_req_valid),
        .i_req_addr    (i_req_addr),
        .i_uncache     (i_uncache),
        .o_req_ready   (o_req_ready),
        .o_resp_valid  (o_resp_valid),
        .o_resp_addr   (o_resp_addr),
        .o_resp_data   (o_resp_data),
        .o_fault       (o_fault),
        .i_cacop_valid (i_cacop_valid),
        .i_cacop_code  (i_cacop_code),
        .o_cacop_done  (o_cacop_done),
        .refill        (refill_bus.ctrl),
        .o_rindex      (rindex),
        .i_way0_tagv   (way0_tagv),
        .i_way1_tagv   (way1_tagv),
        .i_way0_line   (way0_line),
        .i_way1_line   (way1_line),
        .o_way_we      (way_we),
        .o_windex      (windex),
        .o_wtagv       (wtagv),
        .o_wline       (wline)
    );

    icache_way_mem u_way0 (
        .clk      (clk),
        .rstn     (rstn),
        .i_rindex (rindex),
        .i_windex (windex),
        .i_we     (way_we[0]),
        .i_wtagv  (wtagv),
        .i_wline  (wline),
        .o_tagv   (way0_tagv),
        .o_line   (way0_line)
    );

    icache_way_mem u_way1 (
        .clk      (clk),
        .rstn     (rstn),
        .i_rindex (rindex),
        .i_windex (windex),
        .i_we     (way_we[1]),
        .i_wtagv  (wtagv),
        .i_wline  (wline),
        .o_tagv   (way1_tagv),
        .o_line   (way1_line)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rstn        (rstn),
        .refill      (refill_bus.refill),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr),
        .o_mem_len   (o_mem_len),
        .i_mem_ready (i_mem_ready),
        .i_mem_data  (i_mem_data)
    );

endmodule

// ==== verification/tb_icache.sv ====
module tb_icache;
    localparam int TOTAL_REQ = 124;             // requests issued over all tests
    localparam int TIMEOUT   = 20 * TOTAL_REQ;

    logic         clk;
    logic         rstn;
    logic         i_req_valid;
    logic [31:0]  i_req_addr;
    logic         i_uncache;
    logic         o_req_ready;
    logic         o_resp_valid;
    logic [31:0]  o_resp_addr;
    logic [63:0]  o_resp_data;
    logic [6:0]   o_fault;
    logic         i_cacop_valid;
    logic [1:0]   i_cacop_code;
    logic         o_cacop_done;
    logic         o_mem_req;
    logic [31:0]  o_mem_addr;
    logic [7:0]   o_mem_len;
    logic         i_mem_ready;
    logic [511:0] i_mem_data;

    integer seed;
    int     checks;
    int     errors;
    int     cycles;
    int     test_checks;
    int     test_errors;

    // reference tag/valid and LRU per set
    logic [19:0] m_tag   [64][2];
    logic        m_valid [64][2];
    logic        m_lru   [64];

    icache_top icache_top_inst (.*);

    tb_mem_model mem (
        .clk         (clk),
        .i_mem_req   (o_mem_req),
        .i_mem_addr  (o_mem_addr),
        .o_mem_ready (i_mem_ready),
        .o_mem_data  (i_mem_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // predicts a memory access and updates the model
    task automatic model_fetch(input logic [31:0] a, input logic unc, output logic mem_exp);
        logic [5:0]  idx;
        logic [19:0] tg;
        int          w;
        idx = a[11:6];
        tg  = a[31:12];
        if (a[1:0] != 2'b00) begin
            mem_exp = 1'b0;
        end else if (unc) begin
            mem_exp = 1'b1;                     // never allocates
        end else begin
            mem_exp = 1'b1;
            for (w = 0; w < 2; w++) begin
                if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                    mem_exp    = 1'b0;
                    m_lru[idx] = (w == 0);
                end
            end
            if (mem_exp) begin
                w              = int'(m_lru[idx]);
                m_valid[idx][w] = 1'b1;
                m_tag[idx][w]   = tg;
                m_lru[idx]      = ~m_lru[idx];
            end
        end
    endtask

    function automatic logic [63:0] dword_of(input logic [31:0] a);
        logic [31:0] da;
        da = {a[31:3], 3'b000};
        return {(da + 32'd4) ^ 32'h5a5a0000, da ^ 32'h5a5a0000};
    endfunction

    task automatic fetch(input logic [31:0] a, input logic unc, input string name);
        logic        mem_exp;
        logic        seen_mem;
        int          cyc;
        int          req_cyc;
        int          hs_cyc;
        logic [31:0] maddr;
        logic [7:0]  mlen;
        model_fetch(a, unc, mem_exp);
        @(posedge clk);
        #1;
        i_req_valid = 1'b1;
        i_req_addr  = a;
        i_uncache   = unc;
        @(negedge clk);
        while (!o_req_ready) @(negedge clk);
        @(posedge clk);                         // accepted here
        #1;
        i_req_valid = 1'b0;
        cyc      = 0;
        req_cyc  = 0;
        hs_cyc   = 0;
        seen_mem = 1'b0;
        maddr    = '0;
        mlen     = '0;
        do begin
            @(negedge clk);
            cyc++;
            if (o_mem_req && !seen_mem) begin
                seen_mem = 1'b1;
                req_cyc  = cyc;
                maddr    = o_mem_addr;
                mlen     = o_mem_len;
            end
            if (o_mem_req && i_mem_ready) hs_cyc = cyc;
        end while (!o_resp_valid);
        check({name, " mem_req"}, 64'(mem_exp), 64'(seen_mem));
        if (mem_exp && seen_mem) begin
            check({name, " mem_req cycle"}, 64'd1, 64'(req_cyc));
            check({name, " resp cycle"}, 64'(hs_cyc + 1), 64'(cyc));
            if (unc) begin
                check({name, " mem_addr"}, 64'({a[31:3], 3'b000}), 64'(maddr));
                check({name, " mem_len"}, 64'(icache_pkg::UNCACHE_LEN), 64'(mlen));
            end else begin
                check({name, " mem_addr"}, 64'({a[31:6], 6'd0}), 64'(maddr));
                check({name, " mem_len"}, 64'(icache_pkg::REFILL_LEN), 64'(mlen));
            end
        end else begin
            check({name, " resp cycle"}, 64'd1, 64'(cyc));
        end
        check({name, " resp_addr"}, 64'(a), 64'(o_resp_addr));
        if (a[1:0] != 2'b00) begin
            check({name, " fault"}, 64'(icache_pkg::FAULT_ADEF), 64'(o_fault));
            check({name, " data"}, 64'd0, o_resp_data);
        end else begin
            check({name, " fault"}, 64'd0, 64'(o_fault));
            check({name, " data"}, dword_of(a), o_resp_data);
            // a hit or a refill takes the next request at once
            check({name, " req_ready"}, 64'd1, 64'(o_req_ready));
        end
    endtask

    task automatic cacop(input logic [31:0] a, input logic [1:0] code, input string name);
        logic [5:0] idx;
        int         cyc;
        idx = a[11:6];
        if (code == icache_pkg::index_invalidate) begin
            m_valid[idx][a[0]] = 1'b0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[idx][w] && m_tag[idx][w] == a[31:12]) m_valid[idx][w] = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        i_cacop_valid = 1'b1;
        i_cacop_code  = code;
        i_req_addr    = a;
        @(posedge clk);                         // taken in idle
        #1;
        i_cacop_valid = 1'b0;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!o_cacop_done);
        check({name, " done cycle"}, 64'd2, 64'(cyc));
    endtask

    // small region, so tags and sets repeat often
    function automatic logic [31:0] near_addr();
        logic [19:0] tg;
        logic [5:0]  idx;
        logic [3:0]  off;
        tg  = 20'h00010 + 20'({$random(seed)} % 4);
        idx = 6'({$random(seed)} % 4);
        off = 4'($random(seed));
        return {tg, idx, off, 2'b00};
    endfunction

    initial begin
        logic [31:0] a;
        logic [1:0]  code;
        clk           = 1'b0;
        rstn          = 1'b0;
        i_req_valid   = 1'b0;
        i_req_addr    = '0;
        i_uncache     = 1'b0;
        i_cacop_valid = 1'b0;
        i_cacop_code  = '0;
        seed          = 1;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        test_checks   = 0;
        test_errors   = 0;
        for (int s = 0; s < 64; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        @(negedge clk);
        check("reset req_ready", 64'd1, 64'(o_req_ready));
        check("reset resp_valid", 64'd0, 64'(o_resp_valid));
        check("reset mem_req", 64'd0, 64'(o_mem_req));
        check("reset cacop_done", 64'd0, 64'(o_cacop_done));
        end_test("reset");

        for (int i = 0; i < 60; i++) fetch(near_addr(), 1'b0, "cached");
        end_test("cached_hit_miss");

        for (int i = 0; i < 12; i++) begin
            a = {20'h00100 + 20'({$random(seed)} % 3), 6'd40, 4'($random(seed)), 2'b00};
            fetch(a, 1'b0, "lru");
        end
        end_test("lru_replace");

        for (int i = 0; i < 10; i++) begin
            a = {$random(seed)} & 32'hffff_fffc;
            fetch(a, 1'b1, "uncached");
            fetch(a, 1'b1, "uncached repeat");
        end
        end_test("uncached");

        for (int i = 0; i < 8; i++) begin
            a    = near_addr();
            code = ({$random(seed)} % 2 == 0) ? 2'(icache_pkg::index_invalidate)
                                              : 2'(icache_pkg::hit_invalidate);
            fetch(a, 1'b0, "cacop before");
            if (code == icache_pkg::index_invalidate) begin
                cacop({a[31:1], 1'($random(seed))}, code, "index_invalidate");
            end else begin
                cacop(a, code, "hit_invalidate");
            end
            fetch(a, 1'b0, "cacop after");
        end
        end_test("cache_ops");

        for (int i = 0; i < 8; i++) begin
            a = near_addr() | 32'(({$random(seed)} % 3) + 1);
            fetch(a, 1'($random(seed)), "misaligned");
        end
        end_test("misaligned");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_mem_model.sv ====
module tb_mem_model (
    input  logic         clk,
    input  logic         i_mem_req,
    input  logic [31:0]  i_mem_addr,
    output logic         o_mem_ready,
    output logic [511:0] o_mem_data
);
    integer seed;

    initial begin
        seed        = 1;
        o_mem_ready = 1'b0;
    end

    // ready only while a request is up, after a random wait
    always @(posedge clk) begin
        #1;
        o_mem_ready = i_mem_req && (({$random(seed)} % 2) == 0);
    end

    // word at byte address A is A ^ 32'h5a5a0000, byte 0 in the low word
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            o_mem_data[i*32 +: 32] = (i_mem_addr + 32'(i * 4)) ^ 32'h5a5a0000;
        end
    end

endmodule
